// File: Makefile
TOP = rv64i_control_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f rv64i_control.f --top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// File: bench/rv64i_control_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rv64i_control_assert (
    input logic clock,
    input logic reset,
    input logic instruction_mem_enable,
    input logic data_mem_enable,
    input logic pc_enable,
    input logic write_register_enable,
    input rv64i_pkg::cu_state_t state
);
    import rv64i_pkg::*;

    // Instruction and data memory never requested together
    enables_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(instruction_mem_enable && data_mem_enable))
        else $error("instruction and data memory enables high in the same cycle");

    register_write_with_pc: assert property (@(posedge clock) disable iff (reset)
        write_register_enable |-> pc_enable)
        else $error("register write without pc_enable");

    // Every enable lasts exactly one cycle
    instruction_enable_pulse: assert property (@(posedge clock) disable iff (reset)
        instruction_mem_enable |=> !instruction_mem_enable)
        else $error("instruction_mem_enable high for more than one cycle");

    data_enable_pulse: assert property (@(posedge clock) disable iff (reset)
        data_mem_enable |=> !data_mem_enable)
        else $error("data_mem_enable high for more than one cycle");

    pc_enable_pulse: assert property (@(posedge clock) disable iff (reset)
        pc_enable |=> !pc_enable)
        else $error("pc_enable high for more than one cycle");

    // Next instruction is fetched right after the current one ends
    fetch_after_pc_enable: assert property (@(posedge clock) disable iff (reset)
        pc_enable |=> state == st_fetch)
        else $error("no fetch in the cycle after pc_enable");

endmodule

bind control_unit rv64i_control_assert protocol_checks (
    .clock(clock),
    .reset(reset),
    .instruction_mem_enable(instruction_mem_enable),
    .data_mem_enable(data_mem_enable),
    .pc_enable(pc_enable),
    .write_register_enable(write_register_enable),
    .state(state)
);

`default_nettype wire

// File: bench/rv64i_control_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv64i_control_tb;
    import rv64i_pkg::*;

    localparam logic [63:0] reset_vector = 64'h0000_0000_8000_0000;
    localparam int num_instructions = 200;
    localparam int cycles_per_instruction = 25;
    localparam int reset_cycles = 16;
    localparam int clock_period = 100;
    localparam int drive_delay = 5;

    // Order of the legal opcodes for random selection
    localparam logic [6:0] opcode_table [11] = '{op_lui, op_auipc, op_jal, op_jalr, op_branch,
        op_load, op_store, op_imm, op_imm_w, op_reg, op_reg_w};

    typedef struct packed {
        logic alua;
        logic alub;
        logic aluy;
        logic [2:0] alu;
        logic carry;
        logic arith;
        logic [2:0] read;
        logic [1:0] wb;
        logic wre;
    } selectors_t;

    logic clock;
    logic reset;
    logic instruction_mem_busy;
    logic data_mem_busy;
    logic zero;
    logic negative;
    logic carry_out;
    logic overflow;
    logic [31:0] instruction;
    logic [63:0] jalr_base;
    logic instruction_mem_enable;
    logic data_mem_enable;
    logic data_mem_write_enable;
    logic alua_src;
    logic alub_src;
    logic aluy_src;
    logic carry_in;
    logic arithmetic;
    logic write_register_enable;
    logic [2:0] alu_src;
    logic [2:0] read_data_src;
    logic [1:0] write_register_src;
    logic [63:0] pc;
    logic [63:0] immediate;

    logic [31:0] lfsr;
    logic [63:0] expected_pc;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int instr_pulses = 0;
    int data_pulses = 0;
    int memory_ops = 0;

    rv64i_control_top #(.reset_vector(reset_vector)) UUT (.*);

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Worst case instruction is well under the per-instruction budget
    initial begin
        #(clock_period * (reset_cycles + num_instructions * cycles_per_instruction));
        $display("Timeout: the DUT stopped responding before all instructions finished");
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic is_legal(input logic [6:0] op);
        return op inside {op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load, op_store,
                          op_imm, op_imm_w, op_reg, op_reg_w};
    endfunction

    // Branches, loads and stores drawn more often, one in eight illegal
    function automatic logic [31:0] random_instruction();
        logic [31:0] ins;
        logic [3:0] pick;
        ins = rand_bits(32);
        pick = 4'(rand_bits(4));
        if (pick >= 4'd14) begin
            if (is_legal(ins[6:0])) ins[6:0] = 7'b1110011;
        end else begin
            if (pick >= 4'd11) pick = pick - 4'd7;
            ins[6:0] = opcode_table[pick];
        end
        if (ins[6:0] == op_branch && ins[14:13] == 2'b01) ins[14] = 1'b1;
        if (ins[6:0] == op_reg || ins[6:0] == op_reg_w) ins[31:25] = {1'b0, ins[30], 5'b0};
        return ins;
    endfunction

    function automatic selectors_t model_selectors(input logic [31:0] ins);
        selectors_t s;
        logic [6:0] op;
        logic [2:0] f3;
        logic reg_op;
        logic imm_op;
        op = ins[6:0];
        f3 = ins[14:12];
        reg_op = (op == op_reg) || (op == op_reg_w);
        imm_op = (op == op_imm) || (op == op_imm_w);
        s = '0;
        s.alua = (op == op_auipc);
        s.alub = imm_op || op inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_store};
        s.aluy = (op == op_imm_w) || (op == op_reg_w);
        s.alu = (reg_op || imm_op || op == op_branch) ? f3 : 3'b000;
        s.arith = reg_op ? ins[30] : (imm_op && f3 == 3'b101 && ins[30]);
        s.carry = (op == op_branch) || (reg_op && f3 == 3'b000 && ins[30]);
        s.read = (op == op_load) ? f3 : 3'b000;
        if (op == op_load) s.wb = wb_memory;
        else if (op == op_jal || op == op_jalr) s.wb = wb_pc_plus4;
        else if (op == op_lui) s.wb = wb_immediate;
        else s.wb = wb_alu;
        s.wre = is_legal(op) && op != op_branch && op != op_store;
        return s;
    endfunction

    function automatic logic [63:0] model_immediate(input logic [31:0] ins);
        case (ins[6:0])
            op_load, op_imm, op_imm_w, op_jalr: return {{52{ins[31]}}, ins[31:20]};
            op_store: return {{52{ins[31]}}, ins[31:25], ins[11:7]};
            op_branch: return {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            op_lui, op_auipc: return {{32{ins[31]}}, ins[31:12], 12'h000};
            op_jal: return {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default: return 64'd0;
        endcase
    endfunction

    // Flags and jalr_base are the values driven for this instruction
    function automatic logic [63:0] model_next_pc(input logic [31:0] ins,
                                                  input logic [63:0] current);
        logic [63:0] offset;
        logic taken;
        offset = model_immediate(ins);
        case (ins[14:12])
            3'b000: taken = zero;
            3'b001: taken = !zero;
            3'b100: taken = negative ^ overflow;
            3'b101: taken = !(negative ^ overflow);
            3'b110: taken = !carry_out;
            3'b111: taken = carry_out;
            default: taken = 1'b0;
        endcase
        if (ins[6:0] == op_jal) return current + offset;
        if (ins[6:0] == op_jalr) return (jalr_base + offset) & ~64'd1;
        if (ins[6:0] == op_branch && taken) return current + offset;
        return current + 64'd4;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        assert (actual === expected) else begin
            $display("Fail %0t %s actual %h expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    // One clock cycle, sampled at the falling edge
    task automatic sample_cycle();
        logic any_enable;
        @(negedge clock);
        any_enable = instruction_mem_enable | data_mem_enable | data_mem_write_enable
                   | UUT.cu.pc_enable | write_register_enable;
        checks++;
        assert (!(any_enable && (instruction_mem_busy || data_mem_busy))) else begin
            $display("Enable asserted while a memory was busy at %0t", $time);
            errors++;
        end
        if (instruction_mem_enable) instr_pulses++;
        if (data_mem_enable) data_pulses++;
    endtask

    task automatic wait_drive_point();
        @(posedge clock);
        #(drive_delay);
    endtask

    // Busy for length cycles, garbage on the instruction bus meanwhile
    task automatic hold_busy(input int length, input logic data_side);
        wait_drive_point();
        if (data_side) begin
            data_mem_busy = 1'b1;
        end else begin
            instruction_mem_busy = 1'b1;
            instruction = rand_bits(32);
        end
        repeat (length) begin
            sample_cycle();
            wait_drive_point();
        end
        data_mem_busy = 1'b0;
        instruction_mem_busy = 1'b0;
    endtask

    task automatic check_reset_outputs();
        check_value("enables and selectors",
                    64'({instruction_mem_enable, data_mem_enable, data_mem_write_enable,
                         write_register_enable, alua_src, alub_src, aluy_src, carry_in,
                         arithmetic, alu_src, read_data_src, write_register_src}), 64'd0);
        check_value("pc", pc, reset_vector);
    endtask

    initial begin
        logic [31:0] ins;
        logic [31:0] flags;
        selectors_t exp_sel;
        int fetch_len;
        int memory_len;
        int errors_before;
        lfsr = 32'heb49b574;
        reset = 1'b1;
        instruction_mem_busy = 1'b0;
        data_mem_busy = 1'b0;
        zero = 1'b0;
        negative = 1'b0;
        carry_out = 1'b0;
        overflow = 1'b0;
        instruction = '0;
        jalr_base = '0;
        expected_pc = reset_vector;

        repeat (reset_cycles - 1) begin
            @(negedge clock);
            check_reset_outputs();
        end
        wait_drive_point();
        reset = 1'b0;
        // Idle cycle right after reset
        sample_cycle();
        check_reset_outputs();
        tests++;
        $display("Reset test: %s", (errors == 0) ? "ok" : "failed");

        for (int i = 0; i < num_instructions; i++) begin
            ins = random_instruction();
            fetch_len = rand_bits(3) + 1;
            memory_len = rand_bits(3) + 1;
            errors_before = errors;
            while (!instruction_mem_enable) sample_cycle();
            hold_busy(fetch_len, 1'b0);
            instruction = ins;
            flags = rand_bits(4);
            zero = flags[0];
            negative = flags[1];
            carry_out = flags[2];
            overflow = flags[3];
            jalr_base = {rand_bits(32), rand_bits(32)};
            if (ins[6:0] == op_load || ins[6:0] == op_store) begin
                memory_ops++;
                sample_cycle();
                while (!data_mem_enable) sample_cycle();
                check_value("data_mem_write_enable", 64'(data_mem_write_enable),
                            64'(ins[6:0] == op_store));
                hold_busy(memory_len, 1'b1);
            end
            sample_cycle();
            while (!UUT.cu.pc_enable) sample_cycle();

            exp_sel = model_selectors(ins);
            check_value("alua_src", 64'(alua_src), 64'(exp_sel.alua));
            check_value("alub_src", 64'(alub_src), 64'(exp_sel.alub));
            check_value("aluy_src", 64'(aluy_src), 64'(exp_sel.aluy));
            check_value("alu_src", 64'(alu_src), 64'(exp_sel.alu));
            check_value("carry_in", 64'(carry_in), 64'(exp_sel.carry));
            check_value("arithmetic", 64'(arithmetic), 64'(exp_sel.arith));
            check_value("read_data_src", 64'(read_data_src), 64'(exp_sel.read));
            check_value("write_register_src", 64'(write_register_src), 64'(exp_sel.wb));
            check_value("write_register_enable", 64'(write_register_enable), 64'(exp_sel.wre));
            check_value("immediate", immediate, model_immediate(ins));
            check_value("instruction_mem_enable pulses", 64'(instr_pulses), 64'(i + 1));
            check_value("data_mem_enable pulses", 64'(data_pulses), 64'(memory_ops));

            expected_pc = model_next_pc(ins, expected_pc);
            sample_cycle();
            check_value("pc", pc, expected_pc);
            tests++;
            $display("Instruction %0d %h: %s", i, ins, (errors == errors_before) ? "ok" : "failed");
        end

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: common/rv64i_pkg.sv
`default_nettype none

package rv64i_pkg;

    // Data path width
    localparam int xlen = 64;

    // Widths of the dataflow selectors
    localparam int alu_src_width = 3;
    localparam int read_data_src_width = 3;
    localparam int wb_src_width = 2;

    // RV64I major opcodes handled by this core
    // U type
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;

    // Jumps
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_jalr = 7'b1100111;

    // Conditional branches, B type
    localparam logic [6:0] op_branch = 7'b1100011;

    // Memory access
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    // Register-immediate arithmetic, full and word width
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_imm_w = 7'b0011011;

    // Register-register arithmetic, full and word width
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_reg_w = 7'b0111011;

    // Sources for the register file write port
    localparam logic [wb_src_width-1:0] wb_alu = 2'b00;
    localparam logic [wb_src_width-1:0] wb_memory = 2'b01;
    localparam logic [wb_src_width-1:0] wb_pc_plus4 = 2'b10;
    localparam logic [wb_src_width-1:0] wb_immediate = 2'b11;

    // Control unit states
    // idle only follows reset, every instruction starts at fetch
    typedef enum logic [2:0] {
        st_idle = 3'd0,
        st_fetch = 3'd1,
        st_fetch_wait = 3'd2,
        st_decode = 3'd3,
        st_execute = 3'd4,
        st_memory = 3'd5,
        st_memory_wait = 3'd6
    } cu_state_t;

    // Memory states are reached only by loads and stores
    // Execute is the last state of every other instruction
    // Busy waits hold until the memory drops busy

endpackage

`default_nettype wire

// File: control_unit/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic clock,
    input  logic reset,
    input  logic instruction_mem_busy,
    input  logic data_mem_busy,
    input  logic zero,
    input  logic negative,
    input  logic carry_out,
    input  logic overflow,
    input  logic [31:0] instruction,
    output logic instruction_mem_enable,
    output logic data_mem_enable,
    output logic data_mem_write_enable,
    output logic pc_enable,
    output logic pc_src,
    output logic alupc_src,
    output logic write_register_enable,
    output logic alua_src,
    output logic alub_src,
    output logic aluy_src,
    output logic [rv64i_pkg::alu_src_width-1:0] alu_src,
    output logic carry_in,
    output logic arithmetic,
    output logic [rv64i_pkg::read_data_src_width-1:0] read_data_src,
    output logic [rv64i_pkg::wb_src_width-1:0] write_register_src,
    output logic [31:0] decoded_instruction
);
    import rv64i_pkg::*;

    cu_state_t state;
    cu_state_t next_state;
    logic [31:0] instruction_reg;
    logic is_load;
    logic is_store;
    logic is_branch;
    logic is_jump;
    logic legal;
    logic memory_access;
    logic branch_taken;
    logic execute_done;
    logic memory_done;

    // Instruction held from end of fetch until the next fetch ends
    // Cleared on reset so idle decodes to all-zero selectors
    always_ff @(posedge clock) begin
        if (reset) begin
            instruction_reg <= '0;
        end else if (state == st_fetch_wait && !instruction_mem_busy) begin
            instruction_reg <= instruction;
        end
    end

    assign decoded_instruction = instruction_reg;

    instruction_decoder decoder (
        .instruction(instruction_reg),
        .alua_src(alua_src),
        .alub_src(alub_src),
        .aluy_src(aluy_src),
        .alu_src(alu_src),
        .carry_in(carry_in),
        .arithmetic(arithmetic),
        .read_data_src(read_data_src),
        .write_register_src(write_register_src),
        .is_load(is_load),
        .is_store(is_store),
        .is_branch(is_branch),
        .is_jump(is_jump),
        .alupc_src(alupc_src),
        .legal(legal)
    );

    assign memory_access = is_load | is_store;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle:        next_state = st_fetch;
            st_fetch:       next_state = st_fetch_wait;
            st_fetch_wait:  next_state = instruction_mem_busy ? st_fetch_wait : st_decode;
            st_decode:      next_state = st_execute;
            st_execute:     next_state = memory_access ? st_memory : st_fetch;
            st_memory:      next_state = st_memory_wait;
            st_memory_wait: next_state = data_mem_busy ? st_memory_wait : st_fetch;
            default:        next_state = st_idle;
        endcase
    end

    // Branch condition from ALU flags of the compare
    always_comb begin
        case (instruction_reg[14:12])
            3'b000:  branch_taken = zero;
            3'b001:  branch_taken = ~zero;
            3'b100:  branch_taken = negative ^ overflow;
            3'b101:  branch_taken = ~(negative ^ overflow);
            3'b110:  branch_taken = ~carry_out;
            3'b111:  branch_taken = carry_out;
            default: branch_taken = 1'b0;
        endcase
    end

    assign pc_src = is_jump | (is_branch & branch_taken);

    // Final cycle of an instruction
    assign execute_done = (state == st_execute) && !memory_access;
    assign memory_done = (state == st_memory_wait) && !data_mem_busy;

    assign instruction_mem_enable = (state == st_fetch);
    assign data_mem_enable = (state == st_memory);
    assign data_mem_write_enable = (state == st_memory) && is_store;
    assign pc_enable = execute_done | memory_done;

    // No write for branches, stores or illegal opcodes
    assign write_register_enable = (execute_done && legal && !is_branch)
                                 | (memory_done && is_load);

endmodule

`default_nettype wire

// File: control_unit/instruction_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder (
    input  logic [31:0] instruction,
    output logic alua_src,
    output logic alub_src,
    output logic aluy_src,
    output logic [rv64i_pkg::alu_src_width-1:0] alu_src,
    output logic carry_in,
    output logic arithmetic,
    output logic [rv64i_pkg::read_data_src_width-1:0] read_data_src,
    output logic [rv64i_pkg::wb_src_width-1:0] write_register_src,
    output logic is_load,
    output logic is_store,
    output logic is_branch,
    output logic is_jump,
    output logic alupc_src,
    output logic legal
);
    import rv64i_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic funct7_30;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7_30 = instruction[30];

    always_comb begin
        alua_src = 1'b0;
        alub_src = 1'b0;
        aluy_src = 1'b0;
        alu_src = '0;
        carry_in = 1'b0;
        arithmetic = 1'b0;
        read_data_src = '0;
        write_register_src = wb_alu;
        is_load = 1'b0;
        is_store = 1'b0;
        is_branch = 1'b0;
        is_jump = 1'b0;
        alupc_src = 1'b0;
        legal = 1'b1;

        case (opcode)
            op_lui: begin
                alub_src = 1'b1;
                write_register_src = wb_immediate;
            end
            op_auipc: begin
                alua_src = 1'b1;
                alub_src = 1'b1;
            end
            op_jal: begin
                alub_src = 1'b1;
                is_jump = 1'b1;
                write_register_src = wb_pc_plus4;
            end
            op_jalr: begin
                // Target base comes from rs1
                alub_src = 1'b1;
                is_jump = 1'b1;
                alupc_src = 1'b1;
                write_register_src = wb_pc_plus4;
            end
            op_branch: begin
                // Compare is a subtraction
                alu_src = funct3;
                carry_in = 1'b1;
                is_branch = 1'b1;
            end
            op_load: begin
                alub_src = 1'b1;
                read_data_src = funct3;
                write_register_src = wb_memory;
                is_load = 1'b1;
            end
            op_store: begin
                alub_src = 1'b1;
                is_store = 1'b1;
            end
            op_imm, op_imm_w: begin
                alub_src = 1'b1;
                aluy_src = (opcode == op_imm_w);
                alu_src = funct3;
                // SRAI vs SRLI
                arithmetic = (funct3 == 3'b101) && funct7_30;
            end
            op_reg, op_reg_w: begin
                aluy_src = (opcode == op_reg_w);
                alu_src = funct3;
                arithmetic = funct7_30;
                // SUB and SUBW need the extra one of two's complement
                carry_in = (funct3 == 3'b000) && funct7_30;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rv64i_control.f
common/rv64i_pkg.sv
control_unit/instruction_decoder.sv
control_unit/control_unit.sv
verilog/immediate_extender.sv
verilog/fetch_unit.sv
verilog/rv64i_control_top.sv
bench/rv64i_control_assert.sv
bench/rv64i_control_tb.sv

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [rv64i_pkg::xlen-1:0] reset_vector = '0
) (
    input  logic clock,
    input  logic reset,
    input  logic pc_enable,
    input  logic pc_src,
    input  logic alupc_src,
    input  logic [rv64i_pkg::xlen-1:0] immediate,
    input  logic [rv64i_pkg::xlen-1:0] jalr_base,
    output logic [rv64i_pkg::xlen-1:0] pc
);
    import rv64i_pkg::*;

    logic [xlen-1:0] base;
    logic [xlen-1:0] target;
    logic [xlen-1:0] next_pc;

    // JALR adds to rs1, JAL and branches add to pc
    assign base = alupc_src ? jalr_base : pc;
    assign target = base + immediate;

    always_comb begin
        if (!pc_src) begin
            next_pc = pc + 64'd4;
        end else if (alupc_src) begin
            // Bit 0 cleared for JALR
            next_pc = {target[xlen-1:1], 1'b0};
        end else begin
            next_pc = target;
        end
    end

    // Program counter, loaded once at the end of each instruction
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (pc_enable) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: verilog/immediate_extender.sv
`timescale 1ns/1ps
`default_nettype none

module immediate_extender (
    input  logic [31:0] instruction,
    output logic [rv64i_pkg::xlen-1:0] immediate
);
    import rv64i_pkg::*;

    logic sign;

    assign sign = instruction[31];

    always_comb begin
        case (instruction[6:0])
            // I type
            op_load, op_imm, op_imm_w, op_jalr: begin
                immediate = {{(xlen-12){sign}}, instruction[31:20]};
            end
            op_store: begin
                immediate = {{(xlen-12){sign}}, instruction[31:25], instruction[11:7]};
            end
            op_branch: begin
                immediate = {{(xlen-13){sign}}, instruction[31], instruction[7],
                             instruction[30:25], instruction[11:8], 1'b0};
            end
            // U type, upper 20 bits
            op_lui, op_auipc: begin
                immediate = {{(xlen-32){sign}}, instruction[31:12], 12'b0};
            end
            op_jal: begin
                immediate = {{(xlen-21){sign}}, instruction[31], instruction[19:12],
                             instruction[20], instruction[30:21], 1'b0};
            end
            // R type and illegal opcodes
            default: begin
                immediate = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rv64i_control_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv64i_control_top #(
    parameter logic [rv64i_pkg::xlen-1:0] reset_vector = '0
) (
    input  logic clock,
    input  logic reset,
    input  logic instruction_mem_busy,
    input  logic data_mem_busy,
    input  logic zero,
    input  logic negative,
    input  logic carry_out,
    input  logic overflow,
    input  logic [31:0] instruction,
    input  logic [rv64i_pkg::xlen-1:0] jalr_base,
    output logic instruction_mem_enable,
    output logic data_mem_enable,
    output logic data_mem_write_enable,
    output logic alua_src,
    output logic alub_src,
    output logic aluy_src,
    output logic carry_in,
    output logic arithmetic,
    output logic write_register_enable,
    output logic [rv64i_pkg::alu_src_width-1:0] alu_src,
    output logic [rv64i_pkg::read_data_src_width-1:0] read_data_src,
    output logic [rv64i_pkg::wb_src_width-1:0] write_register_src,
    output logic [rv64i_pkg::xlen-1:0] pc,
    output logic [rv64i_pkg::xlen-1:0] immediate
);

    logic pc_enable;
    logic pc_src;
    logic alupc_src;
    logic [31:0] decoded_instruction;

    control_unit cu (
        .clock(clock),
        .reset(reset),
        .instruction_mem_busy(instruction_mem_busy),
        .data_mem_busy(data_mem_busy),
        .zero(zero),
        .negative(negative),
        .carry_out(carry_out),
        .overflow(overflow),
        .instruction(instruction),
        .instruction_mem_enable(instruction_mem_enable),
        .data_mem_enable(data_mem_enable),
        .data_mem_write_enable(data_mem_write_enable),
        .pc_enable(pc_enable),
        .pc_src(pc_src),
        .alupc_src(alupc_src),
        .write_register_enable(write_register_enable),
        .alua_src(alua_src),
        .alub_src(alub_src),
        .aluy_src(aluy_src),
        .alu_src(alu_src),
        .carry_in(carry_in),
        .arithmetic(arithmetic),
        .read_data_src(read_data_src),
        .write_register_src(write_register_src),
        .decoded_instruction(decoded_instruction)
    );

    // Immediate from the held instruction, stable through execute and memory
    immediate_extender extender (
        .instruction(decoded_instruction),
        .immediate(immediate)
    );

    fetch_unit #(
        .reset_vector(reset_vector)
    ) fetch (
        .clock(clock),
        .reset(reset),
        .pc_enable(pc_enable),
        .pc_src(pc_src),
        .alupc_src(alupc_src),
        .immediate(immediate),
        .jalr_base(jalr_base),
        .pc(pc)
    );

endmodule

`default_nettype wire
